// ==== common/bus_pkg.sv ====
package bus_pkg;

	// One memory word, also the width of every Wishbone data path
	typedef logic [31:0] wb_word_t;

	// Word address into the shared memory
	typedef logic [7:0] wb_addr_t;

	// Who owns the shared bus
	typedef enum logic {
		M_HOST  = 1'b0,	// Host side, arbiter port 0
		M_MCONT = 1'b1	// Mailbox controller, arbiter port 1
	} master_id_t;

	// Byte lanes per word
	localparam int unsigned WB_SEL_W = $bits(wb_word_t) / 8;

endpackage

// ==== common/mbox_pkg.sv ====
package mbox_pkg;

	// Mailbox poll steps; every step except WAIT_ACK issues one bus transfer
	typedef enum logic [2:0] {
		RD_TXDATA,	// Fetch byte to send
		RD_CTRL,	// Fetch control word
		WR_CTRL,	// Write control back with go cleared
		WR_STATUS,	// Publish status word
		WR_RXDATA,	// Publish pending rx byte
		RD_ACK,		// Check host acknowledge
		WR_ACK,		// Clear acknowledge word
		WAIT_ACK	// Transfer in flight
	} mcont_state_t;

	// Serial frame position, shared by both directions
	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} uart_state_t;

	// Word written to ADR_STATUS
	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [7:0]  rx_count;		// Frames received, wraps
		logic [3:0]  rsvd_lo;
		logic        parity_err;	// Last frame only
		logic        rx_new;		// Sticky until host ack
		logic        tx_done;		// Sticky until host ack
		logic        tx_busy;
	} status_t;

endpackage

// ==== common/mbox_settings.svh ====
`ifndef MBOX_SETTINGS_SVH
`define MBOX_SETTINGS_SVH

// Shared memory size in words
`define MBOX_DEPTH 256

// Mailbox word addresses
`define ADR_TXDATA 8'h01
`define ADR_CTRL   8'h02
`define ADR_ACK    8'h03
`define ADR_STATUS 8'h10
`define ADR_RXDATA 8'h11

// Control word layout
`define CTRL_GO  0
`define CTRL_PAR 1
`define DIV_LSB  16
`define DIV_W    16

`endif

// ==== common/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;
	import bus_pkg::*;

	logic                cyc;
	logic                stb;
	logic                we;
	wb_addr_t            adr;		// Word address
	logic [WB_SEL_W-1:0] sel;		// Byte lanes for writes
	wb_word_t            dat_w;		// Master to slave
	wb_word_t            dat_r;		// Slave to master
	logic                ack;		// One cycle per transfer

	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, sel, dat_w,
		output dat_r, ack
	);

endinterface

// ==== mcont/mcont.sv ====
`timescale 1ns/1ps

`include "mbox_settings.svh"

module mcont (
	input  logic        clk,
	input  logic        nrst,
	wb_if.master        bus_o,
	input  logic        tx_ready_i,
	input  logic        tx_done_i,
	output logic        tx_start_o,
	output logic [7:0]  tx_byte_o,
	output logic [15:0] tx_div_o,
	output logic        tx_par_o,
	input  logic        rx_valid_i,
	input  logic [7:0]  rx_byte_i,
	input  logic        rx_perr_i,
	output logic        irq_o
);
	import bus_pkg::*;
	import mbox_pkg::*;

	mcont_state_t state_q;
	mcont_state_t cur_q;	// Step whose transfer is in flight
	wb_word_t     ctrl_q;	// Latest control word seen
	status_t      status_q;
	logic [7:0]   rx_byte_q;
	logic         rx_pend_q;	// Byte not yet written back

	// Divisor and parity feed both directions
	assign tx_div_o = ctrl_q[`DIV_LSB +: `DIV_W];
	assign tx_par_o = ctrl_q[`CTRL_PAR];
	assign irq_o    = status_q.tx_done | status_q.rx_new;

	assign bus_o.stb = bus_o.cyc;	// Single transfer per cycle
	assign bus_o.sel = '1;			// Whole words only

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state_q    <= RD_TXDATA;
			cur_q      <= RD_TXDATA;
			bus_o.cyc  <= 1'b0;
			tx_start_o <= 1'b0;
			ctrl_q     <= '0;
			status_q   <= '0;
			rx_pend_q  <= 1'b0;
		end else begin
			tx_start_o       <= 1'b0;
			status_q.tx_busy <= ~tx_ready_i;
			case (state_q)
				WAIT_ACK: if (bus_o.ack) begin
					bus_o.cyc <= 1'b0;	// Gap cycle lets the arbiter switch
					case (cur_q)
						RD_TXDATA: state_q <= RD_CTRL;
						RD_CTRL: begin
							ctrl_q <= bus_o.dat_r;
							if (bus_o.dat_r[`CTRL_GO] && tx_ready_i) begin
								tx_start_o <= 1'b1;
								state_q    <= WR_CTRL;
							end else begin
								state_q <= WR_STATUS;	// Go stays set, retried next loop
							end
						end
						WR_CTRL:   state_q <= WR_STATUS;
						WR_STATUS: state_q <= rx_pend_q ? WR_RXDATA : RD_ACK;
						WR_RXDATA: begin
							rx_pend_q <= 1'b0;
							state_q   <= RD_ACK;
						end
						RD_ACK: begin
							if (bus_o.dat_r != '0) begin	// Host acknowledged
								status_q.tx_done <= 1'b0;
								status_q.rx_new  <= 1'b0;
								state_q          <= WR_ACK;
							end else begin
								state_q <= RD_TXDATA;
							end
						end
						default: state_q <= RD_TXDATA;	// After WR_ACK
					endcase
				end
				default: begin	// Issue the step's transfer
					bus_o.cyc <= 1'b1;
					cur_q     <= state_q;
					state_q   <= WAIT_ACK;
				end
			endcase
			// UART events win over a same-cycle clear
			if (tx_done_i)
				status_q.tx_done <= 1'b1;
			if (rx_valid_i) begin
				rx_pend_q           <= 1'b1;	// Overwrites an unsent byte
				status_q.rx_new     <= 1'b1;
				status_q.parity_err <= rx_perr_i;
				status_q.rx_count   <= status_q.rx_count + 8'd1;
			end
		end
	end

	// Address and write data, set up when a step issues
	always_ff @(posedge clk) begin
		if (rx_valid_i)
			rx_byte_q <= rx_byte_i;
		if (state_q == WAIT_ACK && bus_o.ack && cur_q == RD_TXDATA)
			tx_byte_o <= bus_o.dat_r[7:0];
		case (state_q)
			RD_TXDATA: begin
				bus_o.adr <= `ADR_TXDATA;
				bus_o.we  <= 1'b0;
			end
			RD_CTRL: begin
				bus_o.adr <= `ADR_CTRL;
				bus_o.we  <= 1'b0;
			end
			WR_CTRL: begin
				bus_o.adr   <= `ADR_CTRL;
				bus_o.we    <= 1'b1;
				bus_o.dat_w <= ctrl_q & ~(wb_word_t'(1) << `CTRL_GO);
			end
			WR_STATUS: begin
				bus_o.adr   <= `ADR_STATUS;
				bus_o.we    <= 1'b1;
				bus_o.dat_w <= status_q;
			end
			WR_RXDATA: begin
				bus_o.adr   <= `ADR_RXDATA;
				bus_o.we    <= 1'b1;
				bus_o.dat_w <= {24'h0, rx_byte_q};
			end
			RD_ACK: begin
				bus_o.adr <= `ADR_ACK;
				bus_o.we  <= 1'b0;
			end
			WR_ACK: begin
				bus_o.adr   <= `ADR_ACK;
				bus_o.we    <= 1'b1;
				bus_o.dat_w <= '0;
			end
			default: ;	// Hold until ack
		endcase
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

// ==== src/mbox_ram.sv ====
`timescale 1ns/1ps

`include "mbox_settings.svh"

module mbox_ram (
	input logic clk,
	input logic nrst,
	wb_if.slave bus_i
);
	import bus_pkg::*;

	localparam int AW = $clog2(`MBOX_DEPTH);

	wb_word_t       mem [`MBOX_DEPTH];
	logic [AW-1:0]  clr_cnt_q;	// Word being zeroed
	logic           clr_q;		// Clear sweep running
	logic           req;

	// New access only, not the ack cycle, and never during the sweep
	assign req = bus_i.cyc & bus_i.stb & ~bus_i.ack & ~clr_q;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			clr_q     <= 1'b1;
			clr_cnt_q <= '0;
			bus_i.ack <= 1'b0;
		end else begin
			bus_i.ack <= req;	// Answer one cycle after stb
			if (clr_q) begin
				clr_cnt_q <= clr_cnt_q + 1'b1;
				if (clr_cnt_q == AW'(`MBOX_DEPTH - 1))
					clr_q <= 1'b0;	// Last word done
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clr_q) begin
			mem[clr_cnt_q] <= '0;
		end else if (req) begin
			bus_i.dat_r <= mem[bus_i.adr];
			if (bus_i.we) begin
				for (int b = 0; b < WB_SEL_W; b++)
					if (bus_i.sel[b]) mem[bus_i.adr][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
			end
		end
	end

endmodule

// ==== src/uart_mbox_top.sv ====
`timescale 1ns/1ps

module uart_mbox_top (
	input  logic               clk,
	input  logic               nrst,
	input  logic               host_cyc_i,
	input  logic               host_stb_i,
	input  logic               host_we_i,
	input  bus_pkg::wb_addr_t  host_adr_i,
	input  logic [3:0]         host_sel_i,
	input  bus_pkg::wb_word_t  host_dat_i,
	output bus_pkg::wb_word_t  host_dat_o,
	output logic               host_ack_o,
	output logic               uart_tx_o,
	input  logic               uart_rx_i,
	output logic               irq_o
);
	import bus_pkg::*;

	wb_if host_bus ();	// Host, arbiter port 0
	wb_if mc_bus ();	// Controller, arbiter port 1
	wb_if ram_bus ();	// Arbiter to memory

	logic        tx_start, tx_ready, tx_done, tx_par;
	logic [7:0]  tx_byte;
	logic [15:0] tx_div;
	logic        rx_valid, rx_perr;
	logic [7:0]  rx_byte;

	assign host_bus.cyc   = host_cyc_i;
	assign host_bus.stb   = host_stb_i;
	assign host_bus.we    = host_we_i;
	assign host_bus.adr   = host_adr_i;
	assign host_bus.sel   = host_sel_i;
	assign host_bus.dat_w = host_dat_i;
	assign host_dat_o     = host_bus.dat_r;
	assign host_ack_o     = host_bus.ack;

	wb_arbiter #(.RST_LAST(M_MCONT)) i_wb_arbiter (
		.clk(clk), .nrst(nrst), .m0_i(host_bus), .m1_i(mc_bus), .s_o(ram_bus));

	mbox_ram i_mbox_ram (.clk(clk), .nrst(nrst), .bus_i(ram_bus));

	mcont i_mcont (
		.clk(clk), .nrst(nrst), .bus_o(mc_bus),
		.tx_ready_i(tx_ready), .tx_done_i(tx_done), .tx_start_o(tx_start),
		.tx_byte_o(tx_byte), .tx_div_o(tx_div), .tx_par_o(tx_par),
		.rx_valid_i(rx_valid), .rx_byte_i(rx_byte), .rx_perr_i(rx_perr), .irq_o(irq_o));

	uart_tx i_uart_tx (
		.clk(clk), .nrst(nrst), .start_i(tx_start), .byte_i(tx_byte), .div_i(tx_div),
		.par_i(tx_par), .ready_o(tx_ready), .done_o(tx_done), .tx_o(uart_tx_o));

	// Receiver runs off the same control word as the transmitter
	uart_rx i_uart_rx (
		.clk(clk), .nrst(nrst), .div_i(tx_div), .par_i(tx_par), .rx_i(uart_rx_i),
		.valid_o(rx_valid), .byte_o(rx_byte), .perr_o(rx_perr));

endmodule

// ==== src/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter #(
	parameter bus_pkg::master_id_t RST_LAST = bus_pkg::M_MCONT	// Loses first tie
) (
	input logic clk,
	input logic nrst,
	wb_if.slave  m0_i,	// Host
	wb_if.slave  m1_i,	// Mailbox controller
	wb_if.master s_o
);
	import bus_pkg::*;

	master_id_t grant_q;	// Current owner while busy
	master_id_t last_q;		// Owner of the previous cycle
	master_id_t win;
	logic       busy_q;
	logic       sel_m1;
	logic       gnt_cyc;

	// Round robin on a tie, otherwise whoever asks
	always_comb begin
		if (m0_i.cyc && m1_i.cyc)
			win = (last_q == M_HOST) ? M_MCONT : M_HOST;
		else if (m1_i.cyc)
			win = M_MCONT;
		else
			win = M_HOST;
	end

	assign sel_m1  = (grant_q == M_MCONT);
	assign gnt_cyc = sel_m1 ? m1_i.cyc : m0_i.cyc;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			busy_q  <= 1'b0;
			grant_q <= M_HOST;
			last_q  <= RST_LAST;
		end else if (!busy_q) begin
			if (m0_i.cyc || m1_i.cyc) begin
				busy_q  <= 1'b1;
				grant_q <= win;
			end
		end else if (!gnt_cyc) begin	// Owner let go of cyc
			busy_q <= 1'b0;
			last_q <= grant_q;
		end
	end

	// Owner's request onto the slave
	assign s_o.cyc   = busy_q & gnt_cyc;
	assign s_o.stb   = busy_q & (sel_m1 ? m1_i.stb : m0_i.stb);
	assign s_o.we    = sel_m1 ? m1_i.we    : m0_i.we;
	assign s_o.adr   = sel_m1 ? m1_i.adr   : m0_i.adr;
	assign s_o.sel   = sel_m1 ? m1_i.sel   : m0_i.sel;
	assign s_o.dat_w = sel_m1 ? m1_i.dat_w : m0_i.dat_w;

	// Answer goes to the owner only, the other one keeps waiting
	assign m0_i.ack   = busy_q & ~sel_m1 & s_o.ack;
	assign m1_i.ack   = busy_q &  sel_m1 & s_o.ack;
	assign m0_i.dat_r = sel_m1 ? '0 : s_o.dat_r;
	assign m1_i.dat_r = sel_m1 ? s_o.dat_r : '0;

endmodule

// ==== tb.f ====
+incdir+common
common/bus_pkg.sv
common/mbox_pkg.sv
common/wb_if.sv
src/mbox_ram.sv
src/wb_arbiter.sv
mcont/mcont.sv
uart/uart_tx.sv
uart/uart_rx.sv
src/uart_mbox_top.sv
tb/tb_top.sv

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

`include "mbox_settings.svh"

module tb_top;

	localparam int CLK_PERIOD = 4;
	localparam int DIV        = 8;		// Baud divisor for every frame
	localparam int ACK_LIMIT  = 100;	// Cycles one host transfer may wait
	localparam int POLL_LIMIT = 200;	// Mailbox reads before giving up
	localparam int WD_CYCLES  = 20 * 11 * DIV + 5000;

	logic        clk;
	logic        nrst;
	logic        host_cyc_i, host_stb_i, host_we_i;
	logic [7:0]  host_adr_i;
	logic [3:0]  host_sel_i;
	logic [31:0] host_dat_i;
	logic [31:0] host_dat_o;
	logic        host_ack_o;
	logic        uart_tx_o;
	logic        uart_rx_i;
	logic        irq_o;

	logic [31:0] rng_q;
	logic [31:0] spare_q [32];	// Expected words 0x20..0x3F

	uart_mbox_top i_uart_mbox_top (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_run(input string msg);
		$display("TB FAILED");
		$display("%s", msg);
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
			else stop_run($sformatf("Error: %s expected 0x%h actual 0x%h", name, exp, act));
	endtask

	// Ack lasts one cycle per transfer
	assert property (@(posedge clk) disable iff (!nrst) host_ack_o |=> !host_ack_o)
		else stop_run("host_ack_o stayed high for two cycles in a row");

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic draw(output logic [31:0] r);
		rng_q = xorshift(rng_q);
		r     = rng_q;
	endtask

	function automatic logic even_parity(input logic [7:0] b);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			ones += b[i];
		return ones[0];	// Makes the count of ones even
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
		input logic [3:0] sel);
		logic [31:0] m;
		m = old;
		for (int b = 0; b < 4; b++)
			if (sel[b]) m[8*b +: 8] = nw[8*b +: 8];	// Only enabled lanes change
		return m;
	endfunction

	// One classic cycle started on a rising edge
	task automatic host_xfer(input logic we, input logic [7:0] adr, input logic [3:0] sel,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int n;
		n = 0;
		host_cyc_i <= 1'b1;
		host_stb_i <= 1'b1;
		host_we_i  <= we;
		host_adr_i <= adr;
		host_sel_i <= sel;
		host_dat_i <= wdat;
		@(posedge clk);
		while (!host_ack_o) begin
			n++;
			if (n == ACK_LIMIT) stop_run("Host transfer got no host_ack_o in time");
			@(posedge clk);
		end
		rdat = host_dat_o;
		host_cyc_i <= 1'b0;	// Drop right after ack
		host_stb_i <= 1'b0;
		host_we_i  <= 1'b0;
		@(posedge clk);
	endtask

	task automatic host_write(input logic [7:0] adr, input logic [3:0] sel, input logic [31:0] d);
		logic [31:0] unused;
		host_xfer(1'b1, adr, sel, d, unused);
	endtask

	task automatic host_read(input logic [7:0] adr, output logic [31:0] d);
		host_xfer(1'b0, adr, 4'hf, 32'h0, d);
	endtask

	task automatic wait_for_word(input logic [7:0] adr, input logic [31:0] mask,
		input logic [31:0] want, output logic [31:0] rd);
		int n;
		n = 0;
		host_read(adr, rd);
		while ((rd & mask) != want) begin
			n++;
			if (n == POLL_LIMIT)
				stop_run($sformatf(
					"Error: host_dat_o word 0x%h mask 0x%h expected 0x%h actual 0x%h",
					adr, mask, want, rd & mask));
			host_read(adr, rd);
		end
	endtask

	// Serial monitor sampling mid-bit from the falling start edge
	task automatic capture_frame(input logic par_en, output logic [7:0] data,
		output logic par, output logic stop);
		@(posedge clk);
		while (uart_tx_o) @(posedge clk);
		repeat (DIV / 2 - 1) @(posedge clk);
		check_eq("uart_tx_o start bit", 32'd0, {31'h0, uart_tx_o});
		for (int i = 0; i < 8; i++) begin
			repeat (DIV) @(posedge clk);
			data[i] = uart_tx_o;	// LSB first
		end
		par = 1'b0;
		if (par_en) begin
			repeat (DIV) @(posedge clk);
			par = uart_tx_o;
		end
		repeat (DIV) @(posedge clk);
		stop = uart_tx_o;
	endtask

	task automatic send_frame(input logic [7:0] data, input logic par_en, input logic bad_par);
		uart_rx_i <= 1'b0;
		repeat (DIV) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_i <= data[i];
			repeat (DIV) @(posedge clk);
		end
		if (par_en) begin
			uart_rx_i <= even_parity(data) ^ bad_par;	// Flipped on request
			repeat (DIV) @(posedge clk);
		end
		uart_rx_i <= 1'b1;
		repeat (2 * DIV) @(posedge clk);	// Stop bit plus idle
	endtask

	task automatic ack_irq();
		logic [31:0] rd;
		int          n;
		check_eq("irq_o", 32'd1, {31'h0, irq_o});
		host_write(`ADR_ACK, 4'hf, 32'h1);
		n = 0;
		while (irq_o) begin
			n++;
			if (n == POLL_LIMIT) stop_run("irq_o did not fall after the host acknowledge");
			@(posedge clk);
		end
		wait_for_word(`ADR_ACK, 32'hffff_ffff, 32'h0, rd);
	endtask

	task automatic spare_access(input logic write);
		logic [31:0] r, d, got;
		logic [4:0]  idx;
		draw(r);
		draw(d);
		idx = r[4:0];
		if (write) begin
			host_write({3'b001, idx}, r[11:8], d);
			spare_q[idx] = merge_bytes(spare_q[idx], d, r[11:8]);
		end else begin
			host_read({3'b001, idx}, got);
			check_eq($sformatf("host_dat_o word 0x%h", {3'b001, idx}), spare_q[idx], got);
		end
	endtask

	task automatic tx_test(input logic par_en);
		logic [31:0] r, rd;
		logic [7:0]  got;
		logic        par, stop;
		draw(r);
		fork
			capture_frame(par_en, got, par, stop);
			begin
				host_write(`ADR_TXDATA, 4'hf, {24'h0, r[7:0]});
				host_write(`ADR_CTRL, 4'hf, {16'(DIV), 14'h0, par_en, 1'b1});
			end
		join
		check_eq("uart_tx_o data bits", {24'h0, r[7:0]}, {24'h0, got});
		if (par_en) check_eq("uart_tx_o parity bit", {31'h0, even_parity(r[7:0])}, {31'h0, par});
		check_eq("uart_tx_o stop bit", 32'd1, {31'h0, stop});
		wait_for_word(`ADR_CTRL, 32'h1, 32'h0, rd);	// Go cleared by the controller
		check_eq("ADR_CTRL", {16'(DIV), 14'h0, par_en, 1'b0}, rd);
		wait_for_word(`ADR_STATUS, 32'h2, 32'h2, rd);
		ack_irq();
	endtask

	task automatic rx_check(input logic [7:0] b, input logic bad_par, input logic [7:0] cnt0);
		logic [31:0] rd;
		wait_for_word(`ADR_STATUS, 32'h0000_ff00, {16'h0, cnt0 + 8'd1, 8'h0}, rd);
		check_eq("status parity_err", {31'h0, bad_par}, {31'h0, rd[3]});
		check_eq("status rx_new", 32'd1, {31'h0, rd[2]});
		wait_for_word(`ADR_RXDATA, 32'hff, {24'h0, b}, rd);	// Stored even with bad parity
		ack_irq();
	endtask

	task automatic rx_test(input logic bad_par);
		logic [31:0] r, rd;
		draw(r);
		host_read(`ADR_STATUS, rd);
		send_frame(r[7:0], 1'b1, bad_par);
		rx_check(r[7:0], bad_par, rd[15:8]);
	endtask

	// Host traffic against controller polling and a frame on the line
	task automatic traffic_test();
		logic [31:0] r, rd, w;
		draw(r);
		host_read(`ADR_STATUS, rd);
		fork
			send_frame(r[7:0], 1'b1, 1'b0);
			repeat (60) begin
				draw(w);
				spare_access(w[31]);
			end
		join
		rx_check(r[7:0], 1'b0, rd[15:8]);
	endtask

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		stop_run("Watchdog expired before the tests finished");
	end

	initial begin
		logic [31:0] rd;
		nrst       <= 1'b0;
		host_cyc_i <= 1'b0;
		host_stb_i <= 1'b0;
		host_we_i  <= 1'b0;
		host_adr_i <= '0;
		host_sel_i <= '0;
		host_dat_i <= '0;
		uart_rx_i  <= 1'b1;	// Idle line
		rng_q = 32'hc25;
		foreach (spare_q[i]) spare_q[i] = '0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		repeat (300) @(posedge clk);	// RAM clear sweep
		check_eq("uart_tx_o", 32'd1, {31'h0, uart_tx_o});
		check_eq("irq_o", 32'd0, {31'h0, irq_o});
		check_eq("host_ack_o", 32'd0, {31'h0, host_ack_o});
		repeat (48) spare_access(1'b1);
		for (int i = 0; i < 32; i++) begin
			host_read({3'b001, i[4:0]}, rd);
			check_eq($sformatf("host_dat_o word 0x%h", {3'b001, i[4:0]}), spare_q[i], rd);
		end
		tx_test(1'b0);
		tx_test(1'b1);	// Leaves parity on for the receiver
		rx_test(1'b0);
		rx_test(1'b1);
		traffic_test();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic        clk,
	input  logic        nrst,
	input  logic [15:0] div_i,
	input  logic        par_i,
	input  logic        rx_i,
	output logic        valid_o,
	output logic [7:0]  byte_o,
	output logic        perr_o
);
	import mbox_pkg::*;

	uart_state_t state_q;
	logic [1:0]  sync_q;	// Metastability guard
	logic        rx_d_q;	// Previous synced level
	logic [15:0] cnt_q;
	logic [15:0] div_q;
	logic [7:0]  shreg_q;
	logic [2:0]  bit_q;
	logic        par_q;
	logic        perr_q;
	logic        rx_s;
	logic        hit;		// Mid-bit sample point

	assign rx_s = sync_q[1];
	// Half a bit to the start center, then whole bits
	assign hit  = (cnt_q == ((state_q == START) ? (div_q >> 1) - 16'd1 : div_q - 16'd1));

	always_ff @(posedge clk) begin
		if (!nrst) begin
			sync_q  <= 2'b11;
			rx_d_q  <= 1'b1;
			state_q <= IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			valid_o <= 1'b0;
		end else begin
			sync_q  <= {sync_q[0], rx_i};
			rx_d_q  <= rx_s;
			valid_o <= 1'b0;
			cnt_q   <= (state_q == IDLE || hit) ? 16'd0 : cnt_q + 16'd1;
			case (state_q)
				IDLE: if (rx_d_q && !rx_s) state_q <= START;	// Falling edge
				START: if (hit) begin
					state_q <= rx_s ? IDLE : DATA;	// Reject glitch
					bit_q   <= '0;
				end
				DATA: if (hit) begin
					bit_q <= bit_q + 3'd1;
					if (bit_q == 3'd7) state_q <= par_q ? PARITY : STOP;
				end
				PARITY: if (hit) state_q <= STOP;
				STOP: if (hit) begin
					state_q <= IDLE;
					valid_o <= 1'b1;	// Middle of stop bit
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == IDLE && rx_d_q && !rx_s) begin
			div_q <= div_i;
			par_q <= par_i;
		end
		if (state_q == DATA && hit)
			shreg_q <= {rx_s, shreg_q[7:1]};	// LSB arrives first
		if (state_q == PARITY && hit)
			perr_q <= ^{shreg_q, rx_s};	// Odd count of ones is an error
		if (state_q == STOP && hit) begin
			byte_o <= shreg_q;
			perr_o <= par_q & perr_q;
		end
	end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic        clk,
	input  logic        nrst,
	input  logic        start_i,
	input  logic [7:0]  byte_i,
	input  logic [15:0] div_i,
	input  logic        par_i,
	output logic        ready_o,
	output logic        done_o,
	output logic        tx_o
);
	import mbox_pkg::*;

	uart_state_t state_q;
	logic [15:0] cnt_q;		// Cycles into current bit
	logic [15:0] div_q;
	logic [7:0]  shreg_q;	// Bit 0 is on the line
	logic [2:0]  bit_q;
	logic        par_q;
	logic        pbit_q;	// Even parity of the byte
	logic        bit_end;

	assign bit_end = (cnt_q == div_q - 16'd1);
	assign ready_o = (state_q == IDLE);

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state_q <= IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			tx_o    <= 1'b1;	// Line idles high
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			cnt_q  <= (state_q == IDLE || bit_end) ? 16'd0 : cnt_q + 16'd1;
			case (state_q)
				IDLE: if (start_i) begin
					state_q <= START;
					tx_o    <= 1'b0;
				end
				START: if (bit_end) begin
					state_q <= DATA;
					bit_q   <= '0;
					tx_o    <= shreg_q[0];	// LSB first
				end
				DATA: if (bit_end) begin
					bit_q <= bit_q + 3'd1;
					if (bit_q == 3'd7) begin
						state_q <= par_q ? PARITY : STOP;
						tx_o    <= par_q ? pbit_q : 1'b1;
					end else begin
						tx_o <= shreg_q[1];
					end
				end
				PARITY: if (bit_end) begin
					state_q <= STOP;
					tx_o    <= 1'b1;
				end
				STOP: if (bit_end) begin
					state_q <= IDLE;
					done_o  <= 1'b1;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Frame settings sampled at start
	always_ff @(posedge clk) begin
		if (state_q == IDLE && start_i) begin
			shreg_q <= byte_i;
			div_q   <= div_i;
			par_q   <= par_i;
			pbit_q  <= ^byte_i;
		end else if (state_q == DATA && bit_end) begin
			shreg_q <= shreg_q >> 1;
		end
	end

endmodule
